/* hw/scope_pkg.sv */
/* Shared constants and encodings of the capture scope.
   The sample memory holds MEM_BYTES 8-bit samples, mapped on the bus from MEM_BASE. */

`default_nettype none

package scope_pkg;

    localparam int MEM_BYTES = 256;  // Number of sample bytes
    localparam int MEM_AW    = 8;    // Sample memory address width
    localparam int BUS_AW    = 16;   // Host bus address width
    localparam int MEM_BASE  = 16;   // Bus address of sample byte 0

    // Register map below MEM_BASE
    // Addresses 6 to 15 are unused and read as zero
    typedef enum logic [3:0] {
        REG_RESET    = 4'd0,  // Write only, soft reset
        REG_START    = 4'd1,  // Write starts a capture, bit 0 reads done
        REG_TRIG     = 4'd2,  // Bit 0 is the trigger enable
        REG_COUNT_LO = 4'd3,  // Sample count, low byte
        REG_COUNT_HI = 4'd4,  // Sample count, high byte
        REG_DIV      = 4'd5   // Sample-rate divider
    } reg_addr_t;

    // Capture state machine
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,  // Waiting for start or trigger
        ST_ARM     = 2'd1,  // One cycle to clear the timer
        ST_CAPTURE = 2'd2   // Writing samples
    } state_t;

endpackage

`default_nettype wire

/* hw/scope_regs.sv */
/* Host bus decoder and configuration registers of the capture scope.
   Every read, register or memory, shows on bus_data_out two edges after bus_rd is sampled.
   A write to REG_RESET clears the configuration registers, never the sample memory. */

`default_nettype none

module scope_regs (
    input  wire logic                        BUS_CLK,
    input  wire logic                        RST,
    input  wire logic [scope_pkg::BUS_AW-1:0] bus_add,
    input  wire logic [7:0]                  bus_data_in,
    input  wire logic                        bus_wr,
    input  wire logic                        bus_rd,
    output logic      [7:0]                  bus_data_out,
    input  wire logic                        done,
    input  wire logic [7:0]                  host_rdata,
    output logic                             start,
    output logic                             soft_rst,
    output logic                             trig_en,
    output logic      [15:0]                 conf_count,
    output logic      [7:0]                  conf_div,
    output logic      [scope_pkg::MEM_AW-1:0] host_addr,
    output logic                             host_we,
    output logic      [7:0]                  host_wdata
);

    import scope_pkg::*;

    logic              is_reg;      // Address falls in the register block
    logic              in_mem;      // Address falls in the sample window
    logic [BUS_AW-1:0] mem_off;     // Address relative to MEM_BASE
    reg_addr_t         reg_sel;
    logic [7:0]        reg_byte;    // Register value for the current address
    logic [7:0]        rd_byte_q;   // First read stage
    logic              rd_mem_q;    // First read stage selects the memory

    assign mem_off = bus_add - BUS_AW'(MEM_BASE);
    assign is_reg  = bus_add < BUS_AW'(MEM_BASE);
    assign in_mem  = !is_reg && (mem_off < BUS_AW'(MEM_BYTES));
    assign reg_sel = reg_addr_t'(bus_add[3:0]);

    // Strobes last exactly as long as the bus_wr pulse
    assign start    = bus_wr && is_reg && (reg_sel == REG_START);
    assign soft_rst = bus_wr && is_reg && (reg_sel == REG_RESET);

    assign host_addr  = mem_off[MEM_AW-1:0];
    assign host_we    = bus_wr && in_mem;
    assign host_wdata = bus_data_in;

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            trig_en    <= 1'b0;
            conf_count <= 16'(MEM_BYTES);  // Full memory by default
            conf_div   <= 8'd0;
        end else if (bus_wr && is_reg) begin
            case (reg_sel)
                REG_TRIG:     trig_en <= bus_data_in[0];
                REG_COUNT_LO: conf_count[7:0] <= bus_data_in;
                REG_COUNT_HI: conf_count[15:8] <= bus_data_in;
                REG_DIV:      conf_div <= bus_data_in;
                default:      ;  // Strobe addresses and unused ones store nothing
            endcase
        end
    end

    always_comb begin
        case (reg_sel)
            REG_START:    reg_byte = {7'd0, done};
            REG_TRIG:     reg_byte = {7'd0, trig_en};
            REG_COUNT_LO: reg_byte = conf_count[7:0];
            REG_COUNT_HI: reg_byte = conf_count[15:8];
            REG_DIV:      reg_byte = conf_div;
            default:      reg_byte = 8'd0;  // REG_RESET is write only
        endcase
    end

    // The register byte waits one stage here while the memory does its registered read
    always_ff @(posedge BUS_CLK) begin
        if (bus_rd && is_reg) begin
            rd_byte_q <= reg_byte;
        end else begin
            rd_byte_q <= 8'd0;  // Unmapped addresses read zero
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_mem_q <= 1'b0;
        end else begin
            rd_mem_q <= bus_rd && in_mem;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        bus_data_out <= rd_mem_q ? host_rdata : rd_byte_q;  // Second read stage
    end

endmodule

`default_nettype wire

/* hw/scope_ctrl.sv */
/* Capture state machine. Start and trigger are taken only in ST_IDLE,
   a trigger arriving during a capture is dropped and does not restart it. */

`default_nettype none

module scope_ctrl (
    input  wire logic BUS_CLK,
    input  wire logic RST,
    input  wire logic soft_rst,
    input  wire logic start,
    input  wire logic trigger,
    input  wire logic trig_en,
    input  wire logic last,
    output logic      clear,
    output logic      run,
    output logic      done
);

    import scope_pkg::*;

    state_t state;
    logic   go;  // Capture request

    assign go = start || (trig_en && trigger);

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            state <= ST_IDLE;
            done  <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_ARM;
                        done  <= 1'b0;
                    end
                end
                ST_ARM: begin
                    state <= ST_CAPTURE;  // Timer is cleared during this cycle
                end
                ST_CAPTURE: begin
                    if (last) begin
                        state <= ST_IDLE;  // Final sample is written at this same edge
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    assign clear = (state == ST_ARM);
    assign run   = (state == ST_CAPTURE);

endmodule

`default_nettype wire

/* hw/scope_timer.sv */
/* Sample-rate divider and sample index of a capture. One sample every conf_div+1 cycles.
   conf_count is clamped here to 1..MEM_BYTES, so a count of 0 still takes one sample. */

`default_nettype none

module scope_timer (
    input  wire logic                        BUS_CLK,
    input  wire logic                        RST,
    input  wire logic                        clear,
    input  wire logic                        run,
    input  wire logic [15:0]                 conf_count,
    input  wire logic [7:0]                  conf_div,
    output logic                             cap_we,
    output logic      [scope_pkg::MEM_AW-1:0] cap_addr,
    output logic                             last
);

    import scope_pkg::*;

    logic [7:0]        div_cnt;   // Cycles left until the next sample
    logic [MEM_AW-1:0] idx;       // Address of the next sample
    logic [MEM_AW-1:0] last_idx;  // Address of the final sample
    logic              tick;

    always_comb begin
        if (conf_count == 16'd0) begin
            last_idx = '0;
        end else if (conf_count > 16'(MEM_BYTES)) begin
            last_idx = MEM_AW'(MEM_BYTES - 1);
        end else begin
            last_idx = MEM_AW'(conf_count - 16'd1);
        end
    end

    assign tick = run && (div_cnt == 8'd0);

    always_ff @(posedge BUS_CLK) begin
        if (RST || clear) begin
            div_cnt <= 8'd0;  // First sample is taken right after the clear
            idx     <= '0;
        end else if (tick) begin
            div_cnt <= conf_div;
            idx     <= idx + 1'b1;
        end else if (run) begin
            div_cnt <= div_cnt - 8'd1;
        end
    end

    assign cap_we   = tick;
    assign cap_addr = idx;
    assign last     = tick && (idx == last_idx);  // Comes with the final write strobe

endmodule

`default_nettype wire

/* hw/scope_mem.sv */
/* Sample memory with a host port (read and write) and a capture write port.
   Host reads are registered. When both ports write one address, the capture write wins. */

`default_nettype none

module scope_mem (
    input  wire logic                        BUS_CLK,
    input  wire logic [scope_pkg::MEM_AW-1:0] host_addr,
    input  wire logic                        host_we,
    input  wire logic [7:0]                  host_wdata,
    output logic      [7:0]                  host_rdata,
    input  wire logic                        cap_we,
    input  wire logic [scope_pkg::MEM_AW-1:0] cap_addr,
    input  wire logic [7:0]                  cap_wdata
);

    import scope_pkg::*;

    logic [7:0] mem [MEM_BYTES];
    logic       collide;  // Both ports write the same byte

    // Zero contents keep unknown values out of simulation
    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'd0;
        end
    end

    assign collide = cap_we && host_we && (cap_addr == host_addr);

    always_ff @(posedge BUS_CLK) begin
        if (cap_we) begin
            mem[cap_addr] <= cap_wdata;
        end
        if (host_we && !collide) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];  // Old data on a read during write
    end

endmodule

`default_nettype wire

/* hw/scope_top.sv */
/* Capture scope on a byte-wide register bus, all logic on BUS_CLK.
   sample_in is stored without a register, so the value just before a write edge is kept. */

`default_nettype none

module scope_top (
    input  wire logic                        BUS_CLK,
    input  wire logic                        RST,
    input  wire logic [scope_pkg::BUS_AW-1:0] bus_add,
    input  wire logic [7:0]                  bus_data_in,
    input  wire logic                        bus_wr,
    input  wire logic                        bus_rd,
    output logic      [7:0]                  bus_data_out,
    input  wire logic [7:0]                  sample_in,
    input  wire logic                        trigger
);

    import scope_pkg::*;

    logic              start;
    logic              soft_rst;
    logic              trig_en;
    logic [15:0]       conf_count;
    logic [7:0]        conf_div;
    logic              done;
    logic              clear;
    logic              run;
    logic              last;
    logic              cap_we;
    logic [MEM_AW-1:0] cap_addr;
    logic [MEM_AW-1:0] host_addr;
    logic              host_we;
    logic [7:0]        host_wdata;
    logic [7:0]        host_rdata;

    scope_regs u_regs (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_wr(bus_wr), .bus_rd(bus_rd), .bus_data_out(bus_data_out), .done(done),
        .host_rdata(host_rdata), .start(start), .soft_rst(soft_rst), .trig_en(trig_en),
        .conf_count(conf_count), .conf_div(conf_div), .host_addr(host_addr),
        .host_we(host_we), .host_wdata(host_wdata)
    );

    scope_ctrl u_ctrl (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst), .start(start),
        .trigger(trigger), .trig_en(trig_en), .last(last), .clear(clear),
        .run(run), .done(done)
    );

    scope_timer u_timer (
        .BUS_CLK(BUS_CLK), .RST(RST), .clear(clear), .run(run),
        .conf_count(conf_count), .conf_div(conf_div), .cap_we(cap_we),
        .cap_addr(cap_addr), .last(last)
    );

    scope_mem u_mem (
        .BUS_CLK(BUS_CLK), .host_addr(host_addr), .host_we(host_we),
        .host_wdata(host_wdata), .host_rdata(host_rdata), .cap_we(cap_we),
        .cap_addr(cap_addr), .cap_wdata(sample_in)
    );

endmodule

`default_nettype wire

/* bench/scope_assert.sv */
/* Checks on the capture datapath, bound into scope_top.
   The address check assumes conf_count is not written while a capture runs. */

`default_nettype none

module scope_assert (
    input wire logic                         BUS_CLK,
    input wire logic                         RST,
    input wire logic                         run,
    input wire logic                         cap_we,
    input wire logic [scope_pkg::MEM_AW-1:0] cap_addr,
    input wire logic [15:0]                  conf_count,
    input wire logic                         done
);
    timeunit 1ns;
    timeprecision 1ps;

    import scope_pkg::*;

    int err_cnt = 0;  // Failed assertions so far
    int n_samples;    // Configured sample count, clamped to the memory

    assign n_samples = (conf_count == 16'd0) ? 1
                     : (int'(conf_count) > MEM_BYTES) ? MEM_BYTES : int'(conf_count);

    // The controller holds done low for the whole capture
    a_we_in_run: assert property (@(posedge BUS_CLK) disable iff (RST)
        cap_we |-> (run && !done))
    else begin
        $error("cap_we is high outside a capture");
        err_cnt = err_cnt + 1;
    end

    a_addr_range: assert property (@(posedge BUS_CLK) disable iff (RST)
        cap_we |-> (int'(cap_addr) < n_samples))
    else begin
        $error("cap_addr is beyond the configured sample count");
        err_cnt = err_cnt + 1;
    end

    // The controller comes out of reset idle with the done flag set
    a_done_after_rst: assert property (@(posedge BUS_CLK) RST |=> done)
    else begin
        $error("done is low one cycle after reset");
        err_cnt = err_cnt + 1;
    end

endmodule

bind scope_top scope_assert u_assert (
    .BUS_CLK(BUS_CLK), .RST(RST), .run(run), .cap_we(cap_we),
    .cap_addr(cap_addr), .conf_count(conf_count), .done(done)
);

`default_nettype wire

/* bench/tb_scope.sv */
/* Directed testbench of the capture scope. sample_in follows a count of rising edges,
   so each captured byte is known from the edge at which the capture was started. */

`default_nettype none

module tb_scope;
    timeunit 1ns;
    timeprecision 1ps;

    import scope_pkg::*;

    localparam int WATCHDOG_CYCLES = 6000;  // Summed worst-case test length plus margin
    localparam int MAX_POLLS       = 200;   // Status reads before a capture counts as hung
    localparam int FIRST_OFS       = 2;     // Edges from the start edge to the first write

    logic              BUS_CLK = 1'b0;
    logic              RST;
    logic [BUS_AW-1:0] bus_add;
    logic [7:0]        bus_data_in;
    logic              bus_wr;
    logic              bus_rd;
    logic [7:0]        bus_data_out;
    logic [7:0]        sample_in = 8'd0;
    logic              trigger;

    int         edge_cnt = 0;       // Rising edges seen so far
    int         seed = 12;
    int         go_edge;            // Edge that sampled the latest write or trigger pulse
    logic [7:0] exp_mem [MEM_BYTES];  // Expected sample memory contents

    scope_top u_scope_top (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_wr(bus_wr), .bus_rd(bus_rd), .bus_data_out(bus_data_out),
        .sample_in(sample_in), .trigger(trigger)
    );

    always #5 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK) begin
        edge_cnt <= edge_cnt + 1;
    end

    always @(negedge BUS_CLK) begin
        sample_in <= 8'(edge_cnt);  // Before edge e this holds e-1
    end

    function automatic logic [7:0] sample_before(int e);
        return 8'(e - 1);
    endfunction

    function automatic logic [BUS_AW-1:0] reg_bus_addr(reg_addr_t r);
        return BUS_AW'(r);
    endfunction

    function automatic logic [BUS_AW-1:0] mem_bus_addr(int off);
        return BUS_AW'(MEM_BASE + off);
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s got 0x%02h, expected 0x%02h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic bus_write(input logic [BUS_AW-1:0] addr, input logic [7:0] data);
        @(negedge BUS_CLK);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        go_edge     = edge_cnt + 1;  // Write is sampled at the next rising edge
        @(negedge BUS_CLK);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [BUS_AW-1:0] addr, output logic [7:0] data);
        @(negedge BUS_CLK);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge BUS_CLK);
        @(negedge BUS_CLK);  // Byte is valid after the second sampling edge
        data   = bus_data_out;
        bus_rd = 1'b0;
    endtask

    task automatic read_check(input logic [BUS_AW-1:0] addr, input string name,
                              input logic [7:0] exp);
        logic [7:0] got;
        bus_read(addr, got);
        check(name, got, exp);
    endtask

    task automatic pulse_trigger();
        @(negedge BUS_CLK);
        trigger = 1'b1;
        go_edge = edge_cnt + 1;
        @(negedge BUS_CLK);
        trigger = 1'b0;
    endtask

    task automatic set_capture(input logic [15:0] count, input logic [7:0] div);
        bus_write(reg_bus_addr(REG_COUNT_LO), count[7:0]);
        bus_write(reg_bus_addr(REG_COUNT_HI), count[15:8]);
        bus_write(reg_bus_addr(REG_DIV), div);
    endtask

    // Sample i is written div+1 edges after sample i-1
    task automatic predict_capture(input int k, input int div, input int count);
        int n;
        int i;
        n = count;
        if (n < 1) begin
            n = 1;
        end
        if (n > MEM_BYTES) begin
            n = MEM_BYTES;
        end
        for (i = 0; i < n; i++) begin
            exp_mem[i] = sample_before(k + FIRST_OFS + i * (div + 1));
        end
    endtask

    task automatic check_mem(input int lo, input int hi);
        logic [7:0] got;
        int i;
        for (i = lo; i <= hi; i++) begin
            bus_read(mem_bus_addr(i), got);
            check($sformatf("mem[%0d]", i), got, exp_mem[i]);
        end
    endtask

    task automatic wait_done();
        logic [7:0] status;
        int polls;
        polls  = 0;
        status = 8'd0;
        while (status[0] !== 1'b1) begin
            if (polls == MAX_POLLS) begin
                $display("Capture did not finish after %0d status reads", MAX_POLLS);
                abort_run();
            end
            bus_read(reg_bus_addr(REG_START), status);
            polls++;
        end
    endtask

    task automatic check_reset_values();
        read_check(reg_bus_addr(REG_START), "done", 8'h01);
        read_check(reg_bus_addr(REG_TRIG), "trig_en", 8'h00);
        read_check(reg_bus_addr(REG_COUNT_LO), "count_lo", 8'h00);
        read_check(reg_bus_addr(REG_COUNT_HI), "count_hi", 8'h01);
        read_check(reg_bus_addr(REG_DIV), "div", 8'h00);
        read_check(BUS_AW'(7), "unused reg 7", 8'h00);
    endtask

    task automatic test_reg_access();
        bus_write(reg_bus_addr(REG_TRIG), 8'h01);
        bus_write(reg_bus_addr(REG_COUNT_LO), 8'h34);
        bus_write(reg_bus_addr(REG_COUNT_HI), 8'h12);
        bus_write(reg_bus_addr(REG_DIV), 8'h07);
        read_check(reg_bus_addr(REG_TRIG), "trig_en", 8'h01);
        read_check(reg_bus_addr(REG_COUNT_LO), "count_lo", 8'h34);
        read_check(reg_bus_addr(REG_COUNT_HI), "count_hi", 8'h12);
        read_check(reg_bus_addr(REG_DIV), "div", 8'h07);
        bus_write(reg_bus_addr(REG_RESET), 8'h00);
        check_reset_values();
    endtask

    task automatic test_host_mem();
        logic [7:0] val;
        int i;
        for (i = 32; i < 48; i++) begin
            val        = 8'($random(seed));
            exp_mem[i] = val;
            bus_write(mem_bus_addr(i), val);
        end
        check_mem(32, 47);
    endtask

    task automatic test_capture(input int count, input int div);
        int k;
        set_capture(16'(count), 8'(div));
        bus_write(reg_bus_addr(REG_START), 8'h00);
        k = go_edge;
        predict_capture(k, div, count);
        wait_done();
        check_mem(0, count);  // Byte past the last sample is untouched
    endtask

    task automatic test_trigger();
        int k;
        pulse_trigger();  // trig_en is still 0 here
        repeat (20) @(negedge BUS_CLK);
        read_check(reg_bus_addr(REG_START), "done", 8'h01);
        check_mem(0, 15);
        bus_write(reg_bus_addr(REG_TRIG), 8'h01);
        set_capture(16'd12, 8'd1);
        pulse_trigger();
        k = go_edge;
        predict_capture(k, 1, 12);
        repeat (6) @(negedge BUS_CLK);
        pulse_trigger();  // Lands in the middle of the capture
        wait_done();
        check_mem(0, 15);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge BUS_CLK);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        RST         = 1'b1;
        bus_add     = '0;
        bus_data_in = 8'd0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        trigger     = 1'b0;
        go_edge     = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            exp_mem[i] = 8'd0;  // Memory powers up cleared
        end
        repeat (4) @(negedge BUS_CLK);
        RST = 1'b0;

        check_reset_values();
        test_reg_access();
        test_host_mem();
        test_capture(16, 0);
        test_capture(10, 3);
        test_trigger();

        if (u_scope_top.u_assert.err_cnt != 0) begin
            $display("%0d assertion failures were reported", u_scope_top.u_assert.err_cnt);
            abort_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
hw/scope_pkg.sv
hw/scope_regs.sv
hw/scope_ctrl.sv
hw/scope_timer.sv
hw/scope_mem.sv
hw/scope_top.sv
bench/scope_assert.sv
bench/tb_scope.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the capture scope testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_scope -f project.f

status=0
output=$(./obj_dir/Vtb_scope 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "All checks passed" <<< "$output"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
